// ==== flist.f ====
+incdir+include
design/vic_loader_pkg.sv
design/download_mapper.sv
design/tape_buffer.sv
design/tape_player.sv
design/activity_led.sv
design/clock_enables.sv
design/vic_loader_top.sv
testbench/tb_vic_loader.sv

// ==== include/tb_tasks.svh ====
////////////////////////////////////////////////////////////
// Download and wait tasks, included into the testbench top
// Inputs move 1 ns after the rising edge of clk_sys
////////////////////////////////////////////////////////////
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic tick();
	@(posedge clk_sys);
	#1;
endtask

task automatic begin_download(input logic [7:0] index);
	dl.index    = index;
	dl.download = 1'b1;
	dl.wr       = 1'b0;
	tick();
endtask

// One write strobe, then at least one idle cycle until the stall clears
task automatic send_byte(input logic [24:0] addr, input logic [7:0] data);
	int guard;
	dl.addr = addr;
	dl.data = data;
	dl.wr   = 1'b1;
	tick();
	dl.wr = 1'b0;
	if (dl.index == vic_loader_pkg::IDX_TAPE)
		expect_value("wait_o", 32'(host_wait), 32'd1);
	guard = 0;
	do begin
		tick();
		guard++;
		if (guard > 20)
			timeout_error("wait_o to fall after a tape write");
	end while (host_wait);
endtask

// Index stays put so the falling edge still sees the file type
task automatic end_download();
	dl.download = 1'b0;
	dl.wr       = 1'b0;
	tick();
endtask

task automatic wait_cfg_count(input int n);
	int guard;
	guard = 0;
	while (cfg_log.size() < n) begin
		tick();
		guard++;
		if (guard > 200)
			timeout_error("configuration memory writes");
	end
endtask

`endif

// ==== testbench/tb_vic_loader.sv ====
////////////////////////////////////////////////////////////
// Self-checking testbench for the loader top
// Tape images in these tests stay below 64 bytes
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_vic_loader;

	logic                             clk_sys;
	logic                             reset;
	vic_loader_pkg::dl_stream_t       dl;
	logic [7:0]                       file_ext;
	vic_loader_pkg::host_opts_t       opts;
	logic                             tape_full;
	vic_loader_pkg::cfg_wr_t          cfg;
	logic [vic_loader_pkg::BLK_W-1:0] ram_ext;
	logic [vic_loader_pkg::BLK_W-1:0] ram_ext_ro;
	logic                             host_wait;
	logic                             tape_strobe;
	logic [7:0]                       tape_byte;
	logic                             tape_play;
	logic                             led;
	logic                             core_ce;
	logic                             drive_ce;

	vic_loader_pkg::cfg_wr_t cfg_log [$];
	vic_loader_pkg::cfg_wr_t cfg_exp [$];
	logic [7:0]              tape_log [$];
	logic [7:0]              tape_data [0:63];
	int                      ce_gap;
	bit                      ce_seen;

	task automatic stop_run();
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic value_error(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
		stop_run();
	endtask

	task automatic timeout_error(input string what);
		$display("Timed out waiting for %s", what);
		stop_run();
	endtask

	task automatic expect_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else value_error(name, got, exp);
	endtask

	`include "tb_tasks.svh"

	initial clk_sys = 1'b0;
	always #5 clk_sys = ~clk_sys;

	vic_loader_top uut (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.dl_i               (dl),
		.file_ext_i         (file_ext),
		.opts_i             (opts),
		.tape_full_i        (tape_full),
		.cfg_o              (cfg),
		.ram_ext_o          (ram_ext),
		.ram_ext_ro_o       (ram_ext_ro),
		.wait_o             (host_wait),
		.tape_byte_strobe_o (tape_strobe),
		.tape_byte_o        (tape_byte),
		.tape_play_o        (tape_play),
		.led_o              (led),
		.core_ce_o          (core_ce),
		.drive_ce_o         (drive_ce)
	);

	////////////////////////////////////////////////////////////
	// Monitors
	////////////////////////////////////////////////////////////

	// Deck FIFO full blocks every byte strobe
	assert property (@(posedge clk_sys) disable iff (reset) tape_full |-> !tape_strobe)
		else value_error("tape_byte_strobe_o", 32'(tape_strobe), 32'd0);

	always @(posedge clk_sys) begin
		if (reset) begin
			ce_seen = 1'b0;
			ce_gap  = 0;
		end else begin
			if (cfg.wr)
				cfg_log.push_back(cfg);
			if (tape_strobe)
				tape_log.push_back(tape_byte);
			if (dl.download)
				expect_value("led_o", 32'(led), 32'd1);
			// Core enable once in every four cycles
			if (core_ce) begin
				if (ce_seen)
					expect_value("core_ce_o spacing", 32'(ce_gap), 32'd3);
				ce_seen = 1'b1;
				ce_gap  = 0;
			end else begin
				ce_gap++;
				assert (ce_gap <= 3) else value_error("core_ce_o spacing", 32'(ce_gap), 32'd3);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequences
	////////////////////////////////////////////////////////////

	task automatic apply_reset();
		reset = 1'b1;
		repeat (8) tick();
		expect_value("cfg_o.wr", 32'(cfg.wr), 32'd0);
		expect_value("tape_byte_strobe_o", 32'(tape_strobe), 32'd0);
		expect_value("wait_o", 32'(host_wait), 32'd0);
		expect_value("tape_play_o", 32'(tape_play), 32'd0);
		expect_value("core_ce_o", 32'(core_ce), 32'd0);
		expect_value("drive_ce_o", 32'(drive_ce), 32'd0);
		expect_value("ram_ext_ro_o", 32'(ram_ext_ro), 32'd0);
		reset = 1'b0;
		tick();
	endtask

	// All expected writes, in order, and nothing after them
	task automatic check_cfg_writes();
		wait_cfg_count(cfg_exp.size());
		repeat (6) tick();
		expect_value("cfg_o write count", 32'(cfg_log.size()), 32'(cfg_exp.size()));
		foreach (cfg_exp[i]) begin
			expect_value("cfg_o.addr", 32'(cfg_log[i].addr), 32'(cfg_exp[i].addr));
			expect_value("cfg_o.data", 32'(cfg_log[i].data), 32'(cfg_exp[i].data));
		end
		cfg_log.delete();
		cfg_exp.delete();
	endtask

	task automatic load_prg(input logic [15:0] base, input int n);
		logic [15:0]             a;
		logic [7:0]              b;
		vic_loader_pkg::cfg_wr_t w;
		begin_download(vic_loader_pkg::IDX_PRG);
		send_byte(25'd0, base[7:0]);
		send_byte(25'd1, base[15:8]);
		a = base;
		for (int k = 0; k < n; k++) begin
			b = 8'($urandom);
			send_byte(25'(k + 2), b);
			if (a < vic_loader_pkg::PRG_LIMIT) begin
				w = {1'b1, a, b};
				cfg_exp.push_back(w);
				a++;
			end
		end
		end_download();
		// BASIC pointers take the end address, low byte first
		for (int p = 0; p < 8; p++) begin
			w = {1'b1, vic_loader_pkg::PRG_PTR_ADDR[p], p[0] ? a[15:8] : a[7:0]};
			cfg_exp.push_back(w);
		end
		check_cfg_writes();
	endtask

	task automatic load_rom();
		logic [24:0]             offs [0:4];
		logic [7:0]              b;
		vic_loader_pkg::cfg_wr_t w;
		offs = '{25'h3FFF, 25'h4000, 25'h4001, 25'h7FFF, 25'h8000};
		begin_download(vic_loader_pkg::IDX_ROM);
		for (int k = 0; k < 5; k++) begin
			b = 8'($urandom);
			send_byte(offs[k], b);
			if (offs[k] >= 25'h4000 && offs[k] < 25'h8000) begin
				w = {1'b1, offs[k][15:0] + 16'h8000, b};
				cfg_exp.push_back(w);
			end
		end
		end_download();
		check_cfg_writes();
	endtask

	task automatic test_cartridge();
		logic [7:0]              b;
		logic [2:0]              blk2;
		vic_loader_pkg::cfg_wr_t w;
		// Extension 'A' puts the image at $A000
		file_ext = "A";
		begin_download(vic_loader_pkg::IDX_CART_EXT);
		for (int k = 0; k < 4; k++) begin
			b = 8'($urandom);
			send_byte(25'(k), b);
			w = {1'b1, 16'hA000 + 16'(k), b};
			cfg_exp.push_back(w);
		end
		end_download();
		check_cfg_writes();
		expect_value("ram_ext_ro_o", 32'(ram_ext_ro), 32'h10);
		begin_download(vic_loader_pkg::IDX_CART);
		send_byte(25'd0, 8'h00);
		send_byte(25'd1, 8'h20);
		for (int k = 0; k < 4; k++) begin
			b = 8'($urandom);
			send_byte(25'(k + 2), b);
			w = {1'b1, 16'h2000 + 16'(k), b};
			cfg_exp.push_back(w);
		end
		end_download();
		check_cfg_writes();
		expect_value("ram_ext_ro_o", 32'(ram_ext_ro), 32'h12);
		opts.cart_wr = 1'b1;
		tick();
		expect_value("ram_ext_ro_o", 32'(ram_ext_ro), 32'h00);
		opts.cart_wr = 1'b0;
		// ExtRAM 2 selection is a thermometer code
		for (int i = 0; i < 16; i++) begin
			opts.extram1 = i[0];
			opts.extram2 = i[2:1];
			opts.extram3 = i[3];
			tick();
			blk2 = ~(3'b111 << i[2:1]);
			expect_value("ram_ext_o", 32'(ram_ext), 32'({i[3], blk2, i[0]} | 5'b10010));
		end
		opts = '0;
		apply_reset();
		expect_value("ram_ext_o", 32'(ram_ext), 32'd0);
	endtask

	task automatic test_tape();
		int         n;
		int         guard;
		logic [7:0] b;
		n         = 16;
		tape_full = 1'b1;
		begin_download(vic_loader_pkg::IDX_TAPE);
		for (int k = 0; k < n; k++) begin
			b            = 8'($urandom);
			tape_data[k] = b;
			send_byte(25'(k), b);
		end
		end_download();
		expect_value("tape_play_o", 32'(tape_play), 32'd1);
		repeat (20) tick();
		expect_value("tape byte count", 32'(tape_log.size()), 32'd0);
		// FIFO full on one cycle in five while streaming
		guard = 0;
		while (tape_log.size() < n + 1) begin
			tape_full = (guard % 5 == 2);
			tick();
			guard++;
			if (guard > 2000)
				timeout_error("tape byte strobes");
		end
		tape_full = 1'b0;
		repeat (20) tick();
		expect_value("tape byte count", 32'(tape_log.size()), 32'(n + 1));
		for (int k = 0; k < n; k++)
			expect_value("tape_byte_o", 32'(tape_log[k]), 32'(tape_data[k]));
		for (int p = 0; p < 2; p++) begin
			opts.tape_play_btn = 1'b1;
			tick();
			opts.tape_play_btn = 1'b0;
			tick();
			expect_value("tape_play_o", 32'(tape_play), 32'(p));
		end
		// Unload before the deck has room, nothing may follow
		tape_log.delete();
		tape_full = 1'b1;
		begin_download(vic_loader_pkg::IDX_TAPE);
		for (int k = 0; k < 4; k++)
			send_byte(25'(k), 8'($urandom));
		end_download();
		opts.tape_unload = 1'b1;
		tick();
		opts.tape_unload = 1'b0;
		tape_full        = 1'b0;
		repeat (50) tick();
		expect_value("tape byte count", 32'(tape_log.size()), 32'd0);
		expect_value("led_o", 32'(led), 32'd0);
	endtask

	task automatic measure_drive(input logic pal, input int cycles);
		longint cnt;
		longint freq;
		longint target;
		opts.pal = pal;
		tick();
		cnt = 0;
		for (int c = 0; c < cycles; c++) begin
			tick();
			if (drive_ce)
				cnt++;
		end
		freq   = pal ? longint'(vic_loader_pkg::FREQ_PAL) : longint'(vic_loader_pkg::FREQ_NTSC);
		target = longint'(cycles) * longint'(vic_loader_pkg::CE_STEP);
		assert (cnt * freq > target - freq && cnt * freq < target + freq)
			else value_error("drive_ce_o count", 32'(cnt), 32'(target / freq));
	endtask

	initial begin
		void'($urandom(97));
		reset     = 1'b1;
		dl        = '0;
		file_ext  = 8'h00;
		opts      = '0;
		tape_full = 1'b0;
		apply_reset();
		expect_value("led_o", 32'(led), 32'd0);

		load_prg(16'h1001, 12);
		// Crosses $A000, the last eight bytes are dropped
		load_prg(16'h9FF4, 20);
		load_rom();
		test_cartridge();
		test_tape();
		measure_drive(1'b0, 100000);
		measure_drive(1'b1, 100000);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== design/vic_loader_top.sv ====
////////////////////////////////////////////////////////////
// Loader and tape streamer top, all logic on clk_sys
// Host must hold its next write while wait_o is high
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module vic_loader_top (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  vic_loader_pkg::dl_stream_t          dl_i,
	input  logic [7:0]                          file_ext_i,
	input  vic_loader_pkg::host_opts_t          opts_i,
	input  logic                                tape_full_i,
	output vic_loader_pkg::cfg_wr_t             cfg_o,
	output logic [vic_loader_pkg::BLK_W-1:0]    ram_ext_o,
	output logic [vic_loader_pkg::BLK_W-1:0]    ram_ext_ro_o,
	output logic                                wait_o,
	output logic                                tape_byte_strobe_o,
	output logic [7:0]                          tape_byte_o,
	output logic                                tape_play_o,
	output logic                                led_o,
	output logic                                core_ce_o,
	output logic                                drive_ce_o
);

	// Tape buffer port
	logic                               buf_wr;
	logic                               buf_rd;
	logic [vic_loader_pkg::TAPE_AW-1:0] buf_addr;
	logic [7:0]                         buf_wdata;
	logic [7:0]                         buf_rdata;
	logic                               buf_ready;
	logic                               tape_loaded;

	download_mapper u_download_mapper (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_i         (dl_i),
		.file_ext_i   (file_ext_i),
		.opts_i       (opts_i),
		.cfg_o        (cfg_o),
		.ram_ext_o    (ram_ext_o),
		.ram_ext_ro_o (ram_ext_ro_o)
	);

	tape_buffer u_tape_buffer (
		.clk_sys (clk_sys),
		.wr_i    (buf_wr),
		.rd_i    (buf_rd),
		.addr_i  (buf_addr),
		.data_i  (buf_wdata),
		.data_o  (buf_rdata),
		.ready_o (buf_ready)
	);

	tape_player u_tape_player (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.dl_i               (dl_i),
		.opts_i             (opts_i),
		.tape_full_i        (tape_full_i),
		.buf_wr_o           (buf_wr),
		.buf_rd_o           (buf_rd),
		.buf_addr_o         (buf_addr),
		.buf_data_o         (buf_wdata),
		.buf_data_i         (buf_rdata),
		.buf_ready_i        (buf_ready),
		.wait_o             (wait_o),
		.tape_byte_strobe_o (tape_byte_strobe_o),
		.tape_byte_o        (tape_byte_o),
		.tape_play_o        (tape_play_o),
		.tape_loaded_o      (tape_loaded)
	);

	activity_led u_activity_led (
		.clk_sys       (clk_sys),
		.dl_i          (dl_i),
		.tape_play_i   (tape_play_o),
		.tape_loaded_i (tape_loaded),
		.led_o         (led_o)
	);

	clock_enables u_clock_enables (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.pal_i      (opts_i.pal),
		.core_ce_o  (core_ce_o),
		.drive_ce_o (drive_ce_o)
	);

endmodule

// ==== design/clock_enables.sv ====
////////////////////////////////////////////////////////////
// Core enable every 4th cycle, drive enable by accumulator
// pal_i may change at any time, the rate follows at once
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module clock_enables (
	input  logic clk_sys,
	input  logic reset,
	input  logic pal_i,
	output logic core_ce_o,
	output logic drive_ce_o
);

	logic [1:0]  div;
	logic [31:0] acc;
	logic [31:0] acc_sum;
	logic [31:0] freq;

	assign freq    = pal_i ? vic_loader_pkg::FREQ_PAL : vic_loader_pkg::FREQ_NTSC;
	assign acc_sum = acc + vic_loader_pkg::CE_STEP;

	// Divide by 4
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div       <= 2'd0;
			core_ce_o <= 1'b0;
		end else begin
			div       <= div + 2'd1;
			core_ce_o <= (div == 2'd0);
		end
	end

	////////////////////////////////////////////////////////////
	// Fractional drive enable
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc        <= '0;
			drive_ce_o <= 1'b0;
		end else if (acc_sum >= freq) begin
			acc        <= acc_sum - freq;
			drive_ce_o <= 1'b1;
		end else begin
			acc        <= acc_sum;
			drive_ce_o <= 1'b0;
		end
	end

endmodule

// ==== design/activity_led.sv ====
////////////////////////////////////////////////////////////
// User LED, solid while downloading, PWM with a tape loaded
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module activity_led (
	input  logic                       clk_sys,
	input  vic_loader_pkg::dl_stream_t dl_i,
	input  logic                       tape_play_i,
	input  logic                       tape_loaded_i,
	output logic                       led_o
);

	localparam int AW = vic_loader_pkg::ACT_W;

	logic [AW-1:0] act_cnt = '0;
	logic [7:0]    cnt_hi;
	logic [7:0]    cnt_lo;
	logic          pwm;

	// Faster breathing while the tape plays
	always_ff @(posedge clk_sys) begin
		act_cnt <= act_cnt + (tape_play_i ? AW'(8) : AW'(1));
	end

	assign cnt_hi = act_cnt[AW-2 -: 8];
	assign cnt_lo = act_cnt[7:0];

	// Top bit picks the ramp direction
	assign pwm = act_cnt[AW-1] ? (cnt_hi > cnt_lo) : (cnt_hi <= cnt_lo);

	assign led_o = dl_i.download | (tape_loaded_i & pwm);

endmodule

// ==== design/tape_player.sv ====
////////////////////////////////////////////////////////////
// Tape load into the buffer and byte streaming to the deck
// Images longer than 4 KB wrap inside the buffer
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tape_player (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  vic_loader_pkg::dl_stream_t         dl_i,
	input  vic_loader_pkg::host_opts_t         opts_i,
	input  logic                               tape_full_i,
	output logic                               buf_wr_o,
	output logic                               buf_rd_o,
	output logic [vic_loader_pkg::TAPE_AW-1:0] buf_addr_o,
	output logic [7:0]                         buf_data_o,
	input  logic [7:0]                         buf_data_i,
	input  logic                               buf_ready_i,
	output logic                               wait_o,
	output logic                               tape_byte_strobe_o,
	output logic [7:0]                         tape_byte_o,
	output logic                               tape_play_o,
	output logic                               tape_loaded_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_HOLD
	} play_state_t;

	play_state_t                      state;
	logic [vic_loader_pkg::TAPE_AW:0] play_addr;
	logic [vic_loader_pkg::TAPE_AW:0] last_addr;
	logic                             loading;
	logic                             restart;
	logic                             btn_q;
	logic                             rd_issue;

	assign loading = dl_i.download && (dl_i.index == vic_loader_pkg::IDX_TAPE);
	assign restart = reset | loading | opts_i.tape_unload;

	assign tape_loaded_o = (play_addr < last_addr);

	// No reads while a host write is still in the buffer
	assign rd_issue = ~restart & (state == ST_IDLE) & ~buf_wr_o & ~wait_o &
		~tape_full_i & tape_loaded_o;

	// Byte leaves only while the deck FIFO has room
	assign tape_byte_strobe_o = (state == ST_HOLD) & ~tape_full_i;

	////////////////////////////////////////////////////////////
	// Host write path and stall
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			buf_wr_o <= 1'b0;
			wait_o   <= 1'b0;
		end else begin
			buf_wr_o <= loading & dl_i.wr;
			if (loading && dl_i.wr)
				wait_o <= 1'b1;
			else if (!buf_wr_o && buf_ready_i)
				wait_o <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Play state and streaming
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		btn_q <= opts_i.tape_play_btn;
		if (restart) begin
			// One extra byte past the end, the deck checks its FIFO early
			last_addr <= loading ? {1'b0, dl_i.addr[vic_loader_pkg::TAPE_AW-1:0]} + 2'd2 : '0;
			play_addr   <= '0;
			tape_play_o <= loading;
			buf_rd_o    <= 1'b0;
			state       <= ST_IDLE;
		end else begin
			buf_rd_o <= rd_issue;
			if (opts_i.tape_play_btn && !btn_q)
				tape_play_o <= ~tape_play_o;
			case (state)
				ST_IDLE: begin
					if (rd_issue)
						state <= ST_READ;
				end
				ST_READ: begin
					if (buf_ready_i)
						state <= ST_HOLD;
				end
				ST_HOLD: begin
					if (!tape_full_i) begin
						play_addr <= play_addr + 1'b1;
						state     <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Buffer address, write data and the byte held for the deck
	always_ff @(posedge clk_sys) begin
		if (loading && dl_i.wr) begin
			buf_addr_o <= dl_i.addr[vic_loader_pkg::TAPE_AW-1:0];
			buf_data_o <= dl_i.data;
		end else if (rd_issue) begin
			buf_addr_o <= play_addr[vic_loader_pkg::TAPE_AW-1:0];
		end
		if (state == ST_READ && buf_ready_i)
			tape_byte_o <= buf_data_i;
	end

endmodule

// ==== design/tape_buffer.sv ====
////////////////////////////////////////////////////////////
// Single-port tape image store, read-first on a write
// Data and ready come one cycle after any access
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tape_buffer (
	input  logic                               clk_sys,
	input  logic                               wr_i,
	input  logic                               rd_i,
	input  logic [vic_loader_pkg::TAPE_AW-1:0] addr_i,
	input  logic [7:0]                         data_i,
	output logic [7:0]                         data_o,
	output logic                               ready_o
);

	localparam int DEPTH = 2 ** vic_loader_pkg::TAPE_AW;

	logic [7:0] mem [0:DEPTH-1];

	// Block RAM with registered output
	always_ff @(posedge clk_sys) begin
		if (wr_i)
			mem[addr_i] <= data_i;
		data_o <= mem[addr_i];
	end

	// Ready follows every access, reads and writes alike
	always_ff @(posedge clk_sys) begin
		ready_o <= wr_i | rd_i;
	end

endmodule

// ==== design/download_mapper.sv ====
////////////////////////////////////////////////////////////
// PRG, kernal and cartridge files to config memory writes
// Cart block mask is sticky until reset
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module download_mapper (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  vic_loader_pkg::dl_stream_t          dl_i,
	input  logic [7:0]                          file_ext_i,
	input  vic_loader_pkg::host_opts_t          opts_i,
	output vic_loader_pkg::cfg_wr_t             cfg_o,
	output logic [vic_loader_pkg::BLK_W-1:0]    ram_ext_o,
	output logic [vic_loader_pkg::BLK_W-1:0]    ram_ext_ro_o
);

	logic                             dl_q;
	logic [3:0]                       ptr_state;
	logic [15:0]                      load_addr;
	logic [vic_loader_pkg::BLK_W-1:0] cart_blk;
	logic [2:0]                       extram2_mask;
	logic                             is_prg;
	logic                             is_rom;
	logic                             is_cart;
	logic                             is_cart_ext;
	logic                             dl_rise;
	logic                             dl_fall;
	logic                             abandon;

	// One-hot block bit for an 8 KB page, $8000 and above $A000 have none
	function automatic logic [vic_loader_pkg::BLK_W-1:0] blk_bit(input logic [2:0] page);
		logic [vic_loader_pkg::BLK_W-1:0] mask;
		mask = '0;
		case (page)
			3'b000: mask[0] = 1'b1;
			3'b001: mask[1] = 1'b1;
			3'b010: mask[2] = 1'b1;
			3'b011: mask[3] = 1'b1;
			3'b101: mask[4] = 1'b1;
			default: mask = '0;
		endcase
		return mask;
	endfunction

	assign is_prg      = (dl_i.index == vic_loader_pkg::IDX_PRG);
	assign is_rom      = (dl_i.index == vic_loader_pkg::IDX_ROM);
	assign is_cart     = (dl_i.index == vic_loader_pkg::IDX_CART);
	assign is_cart_ext = (dl_i.index == vic_loader_pkg::IDX_CART_EXT);
	assign dl_rise     = dl_i.download & ~dl_q;
	assign dl_fall     = ~dl_i.download & dl_q;
	assign abandon     = dl_i.download & (is_prg | is_rom);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_q      <= 1'b0;
			ptr_state <= 4'd0;
			cfg_o.wr  <= 1'b0;
			cart_blk  <= '0;
		end else begin
			dl_q     <= dl_i.download;
			cfg_o.wr <= 1'b0;

			////////////////////////////////////////////////////////////
			// BASIC pointer fix-up, odd states write
			////////////////////////////////////////////////////////////
			if (ptr_state != 4'd0)
				ptr_state <= ptr_state + 4'd1;
			if (dl_fall && is_prg)
				ptr_state <= 4'd1;
			if (ptr_state[0] && !abandon) begin
				cfg_o.wr   <= 1'b1;
				cfg_o.addr <= vic_loader_pkg::PRG_PTR_ADDR[ptr_state[3:1]];
				cfg_o.data <= ptr_state[1] ? load_addr[15:8] : load_addr[7:0];
			end

			// PRG file, first two bytes give the load address
			if (dl_i.download && is_prg) begin
				ptr_state <= 4'd0;
				if (dl_i.wr) begin
					if (dl_i.addr == 25'd0) begin
						load_addr[7:0] <= dl_i.data;
					end else if (dl_i.addr == 25'd1) begin
						load_addr[15:8] <= dl_i.data;
					end else if (load_addr < vic_loader_pkg::PRG_LIMIT) begin
						cfg_o.wr   <= 1'b1;
						cfg_o.addr <= load_addr;
						cfg_o.data <= dl_i.data;
						load_addr  <= load_addr + 16'd1;
					end
				end
			end

			// Kernal window
			if (dl_i.download && is_rom) begin
				ptr_state <= 4'd0;
				if (dl_i.wr && dl_i.addr >= vic_loader_pkg::ROM_WIN_LO &&
						dl_i.addr < vic_loader_pkg::ROM_WIN_HI) begin
					cfg_o.wr   <= 1'b1;
					cfg_o.addr <= dl_i.addr[15:0] + vic_loader_pkg::ROM_OFFSET;
					cfg_o.data <= dl_i.data;
				end
			end

			////////////////////////////////////////////////////////////
			// Cartridges
			////////////////////////////////////////////////////////////
			if (dl_i.download && (is_cart || is_cart_ext) && dl_i.wr) begin
				if (is_cart && dl_i.addr == 25'd0) begin
					load_addr[7:0] <= dl_i.data;
				end else if (is_cart && dl_i.addr == 25'd1) begin
					load_addr[15:8] <= dl_i.data;
				end else if (load_addr < vic_loader_pkg::CART_LIMIT) begin
					cart_blk   <= cart_blk | blk_bit(load_addr[15:13]);
					cfg_o.wr   <= 1'b1;
					cfg_o.addr <= load_addr;
					cfg_o.data <= dl_i.data;
					load_addr  <= load_addr + 16'd1;
				end
			end

			// Base from the last extension character, '2'..'9' or 'A'..'B'
			if (dl_rise && is_cart_ext) begin
				if (file_ext_i >= "2" && file_ext_i <= "9")
					load_addr <= {file_ext_i[3:0], 12'h000};
				else if (file_ext_i >= "A" && file_ext_i <= "B")
					load_addr <= {file_ext_i[3:0] + 4'd9, 12'h000};
			end
		end
	end

	// ExtRAM 2 grows upward from $2000 in 8 KB steps
	always_comb begin
		case (opts_i.extram2)
			2'd0: extram2_mask = 3'b000;
			2'd1: extram2_mask = 3'b001;
			2'd2: extram2_mask = 3'b011;
			default: extram2_mask = 3'b111;
		endcase
	end

	assign ram_ext_o    = {opts_i.extram3, extram2_mask, opts_i.extram1} | cart_blk;
	assign ram_ext_ro_o = opts_i.cart_wr ? '0 : cart_blk;

endmodule

// ==== design/vic_loader_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared types and constants of the VIC-20 loader
// Offsets in dl_stream_t are byte offsets into the file
////////////////////////////////////////////////////////////
package vic_loader_pkg;

	////////////////////////////////////////////////////////////
	// Host side structures
	////////////////////////////////////////////////////////////

	// Download stream from the host, one byte per write strobe
	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
		logic        wr;
	} dl_stream_t;

	// One write into the core configuration memory
	typedef struct packed {
		logic        wr;
		logic [15:0] addr;
		logic [7:0]  data;
	} cfg_wr_t;

	// User options as levels
	typedef struct packed {
		logic       extram1;
		logic [1:0] extram2;
		logic       extram3;
		logic       cart_wr;
		logic       pal;
		logic       tape_play_btn;
		logic       tape_unload;
	} host_opts_t;

	////////////////////////////////////////////////////////////
	// File indices and address map
	////////////////////////////////////////////////////////////

	localparam logic [7:0] IDX_ROM      = 8'd0;
	localparam logic [7:0] IDX_PRG      = 8'd1;
	localparam logic [7:0] IDX_CART     = 8'd2;
	localparam logic [7:0] IDX_CART_EXT = 8'd3;
	localparam logic [7:0] IDX_TAPE     = 8'd5;

	localparam logic [15:0] PRG_LIMIT  = 16'hA000;
	localparam logic [15:0] CART_LIMIT = 16'hC000;

	// Kernal lives at file offset $4000-$7FFF
	localparam logic [15:0] ROM_WIN_LO = 16'h4000;
	localparam logic [15:0] ROM_WIN_HI = 16'h8000;
	localparam logic [15:0] ROM_OFFSET = 16'h8000;

	// BASIC pointers patched after a PRG load, entry 0 first
	localparam logic [7:0][15:0] PRG_PTR_ADDR = {
		16'h00AF, 16'h00AE, 16'h0032, 16'h0031,
		16'h0030, 16'h002F, 16'h002E, 16'h002D
	};

	localparam int BLK_W   = 5;
	localparam int TAPE_AW = 12;

	////////////////////////////////////////////////////////////
	// Clock enables and LED
	////////////////////////////////////////////////////////////

	localparam logic [31:0] CE_STEP   = 32'd32000000;
	localparam logic [31:0] FREQ_PAL  = 32'd35468944;
	localparam logic [31:0] FREQ_NTSC = 32'd32727260;

	localparam int ACT_W = 27;

endpackage
